// File: compile.f
logic/nx_pkg.sv
logic/nx_fifo.sv
logic/nx_msg_decoder.sv
logic/nx_instr_store.sv
logic/nx_map_table.sv
logic/nx_input_state.sv
logic/nx_node_ctrl.sv
verif/nx_node_ctrl_sva.sv
verif/tb_nx_node_ctrl.sv

// File: run.sh
#!/bin/sh
# Build and run the node control testbench with Verilator

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -sv -f compile.f \
    --top-module tb_nx_node_ctrl -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$BUILD_DIR/Vtb_nx_node_ctrl" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// File: verif/tb_nx_node_ctrl.sv
// ####################################################################
// Directed testbench for the node control path, with reference model
// ####################################################################
`timescale 1ns/1ps

module tb_nx_node_ctrl;

    localparam int TOTAL_MSGS      = 63;  // Messages over all tests
    localparam int WATCHDOG_CYCLES = TOTAL_MSGS * 20 + 1500;
    localparam int WAIT_LIMIT      = 200; // Per stall or drain

    logic                                   clk = 1'b0;
    logic                                   rst_n;
    nx_pkg::nx_message_t                    msg_data;
    logic                                   msg_valid;
    logic                                   msg_ready;
    logic                                   idle;
    logic [nx_pkg::NX_INSTR_ADDR_WIDTH-1:0] instr_rd_addr;
    logic [nx_pkg::NX_INSTR_WIDTH-1:0]      instr_rd_data;
    logic [nx_pkg::NX_INSTR_CNT_WIDTH-1:0]  instr_count;
    logic                                   instr_full;
    logic [nx_pkg::NX_OUT_IDX_WIDTH-1:0]    map_rd_idx;
    nx_pkg::nx_map_entry_t                  map_rd_entry;
    logic                                   map_rd_valid;
    logic [nx_pkg::NX_INPUTS-1:0]           comb_state;
    logic [nx_pkg::NX_INPUTS-1:0]           seq_state;

    // Reference model
    logic [nx_pkg::NX_INSTR_WIDTH-1:0] m_instr [nx_pkg::NX_INSTR_DEPTH];
    int                                m_count;
    nx_pkg::nx_map_entry_t             m_map [nx_pkg::NX_OUTPUTS];
    logic [nx_pkg::NX_OUTPUTS-1:0]     m_map_valid;
    logic [nx_pkg::NX_INPUTS-1:0]      m_comb;
    logic [nx_pkg::NX_INPUTS-1:0]      m_seq;

    integer seed;
    int     chk_count;
    int     err_count;
    int     test_chk;   // Counts at test start
    int     test_err;
    logic   stall_seen; // Back-pressure observed

    always #20 clk = ~clk; // 40 ns period

    nx_node_ctrl u_nx_node_ctrl (
          .clk_i           (clk)
        , .rst_n_i         (rst_n)
        , .msg_data_i      (msg_data)
        , .msg_valid_i     (msg_valid)
        , .msg_ready_o     (msg_ready)
        , .idle_o          (idle)
        , .instr_rd_addr_i (instr_rd_addr)
        , .instr_rd_data_o (instr_rd_data)
        , .instr_count_o   (instr_count)
        , .instr_full_o    (instr_full)
        , .map_rd_idx_i    (map_rd_idx)
        , .map_rd_entry_o  (map_rd_entry)
        , .map_rd_valid_o  (map_rd_valid)
        , .comb_state_o    (comb_state)
        , .seq_state_o     (seq_state)
    );

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        chk_count++;
        if (got !== exp) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            err_count++;
        end
    endtask

    // Random header and payload, command forced
    function automatic nx_pkg::nx_message_t make_msg(input nx_pkg::nx_command_t cmd);
        nx_pkg::nx_message_t m;
        m                = $random(seed);
        m.header.command = cmd;
        return m;
    endfunction

    task automatic model_apply(input nx_pkg::nx_message_t msg);
        nx_pkg::nx_msg_map_output_t mm;
        nx_pkg::nx_msg_sig_state_t  ms;
        nx_pkg::nx_msg_load_instr_t mi;
        mm = nx_pkg::nx_msg_map_output_t'(msg);
        ms = nx_pkg::nx_msg_sig_state_t'(msg);
        mi = nx_pkg::nx_msg_load_instr_t'(msg);
        case (msg.header.command)
            nx_pkg::NX_CMD_LOAD_INSTR: begin
                if (m_count < nx_pkg::NX_INSTR_DEPTH) begin // Dropped once full
                    m_instr[m_count] = mi.instruction;
                    m_count++;
                end
            end
            nx_pkg::NX_CMD_MAP_OUTPUT: begin
                m_map[mm.source_index] = '{mm.target_row, mm.target_column,
                                           mm.target_index, mm.target_is_seq};
                m_map_valid[mm.source_index] = 1'b1;
            end
            nx_pkg::NX_CMD_SIG_STATE: begin
                if (ms.target_is_seq) m_seq[ms.target_index] = ms.state;
                else                  m_comb[ms.target_index] = ms.state;
            end
            default: ; // Reserved, no effect
        endcase
    endtask

    // Called right after a rising edge, returns right after the transfer edge
    task automatic send_msg(input nx_pkg::nx_message_t msg);
        int   waited;
        logic accepted;
        waited = 0;
        msg_data  <= msg;
        msg_valid <= 1'b1;
        @(negedge clk);
        while (!msg_ready && waited < WAIT_LIMIT) begin
            stall_seen = 1'b1;
            waited++;
            @(negedge clk);
        end
        accepted = msg_ready; // Ready as seen before the transfer edge
        @(posedge clk);
        if (accepted) model_apply(msg);
        else begin
            $display("message was never accepted, msg_ready_o stuck low");
            err_count++;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        msg_valid <= 1'b0;
        @(negedge clk);
        while (!idle && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (!idle) begin
            $display("node did not return to idle after the last message");
            err_count++;
        end
    endtask

    // Status, state vectors, then sweep both read ports
    task automatic compare_all();
        check_val("idle_o", 32'(idle), 32'h1);
        check_val("msg_ready_o", 32'(msg_ready), 32'h1);
        check_val("instr_count_o", 32'(instr_count), 32'(m_count));
        check_val("instr_full_o", 32'(instr_full), 32'(m_count == nx_pkg::NX_INSTR_DEPTH));
        check_val("comb_state_o", 32'(comb_state), 32'(m_comb));
        check_val("seq_state_o", 32'(seq_state), 32'(m_seq));
        for (int a = 0; a < nx_pkg::NX_INSTR_DEPTH; a++) begin
            @(posedge clk);
            instr_rd_addr <= nx_pkg::NX_INSTR_ADDR_WIDTH'(a);
            map_rd_idx    <= nx_pkg::NX_OUT_IDX_WIDTH'(a);
            @(negedge clk);
            if (a < m_count) check_val("instr_rd_data_o", 32'(instr_rd_data), 32'(m_instr[a]));
            if (a < nx_pkg::NX_OUTPUTS) begin
                check_val("map_rd_valid_o", 32'(map_rd_valid), 32'(m_map_valid[a]));
                if (m_map_valid[a]) check_val("map_rd_entry_o", 32'(map_rd_entry), 32'(m_map[a]));
            end
        end
    endtask

    task automatic start_test();
        test_chk = chk_count;
        test_err = err_count;
        @(posedge clk); // Sends start on a rising edge
    endtask

    task automatic finish_test(input string name);
        $display("test %-14s %0d checks, %0d errors", name, chk_count - test_chk,
                 err_count - test_err);
    endtask

    task automatic test_instr_loads(input string name);
        start_test();
        repeat (10) send_msg(make_msg(nx_pkg::NX_CMD_LOAD_INSTR));
        drain();
        compare_all();
        finish_test(name);
    endtask

    task automatic test_map_writes();
        nx_pkg::nx_msg_map_output_t mm;
        start_test();
        for (int k = 0; k < 12; k++) begin
            mm = nx_pkg::nx_msg_map_output_t'(make_msg(nx_pkg::NX_CMD_MAP_OUTPUT));
            // First pass covers 0..5, second repeats them, 6 and 7 stay unwritten
            mm.source_index = (k < 6) ? nx_pkg::NX_OUT_IDX_WIDTH'(k)
                                      : nx_pkg::NX_OUT_IDX_WIDTH'({$random(seed)} % 6);
            send_msg(nx_pkg::nx_message_t'(mm));
        end
        drain();
        compare_all();
        finish_test("map_writes");
    endtask

    task automatic test_sig_updates();
        nx_pkg::nx_msg_sig_state_t ms;
        start_test();
        for (int k = 0; k < 12; k++) begin
            ms       = nx_pkg::nx_msg_sig_state_t'(make_msg(nx_pkg::NX_CMD_SIG_STATE));
            ms.state = (k < 8); // Sets, then clears
            send_msg(nx_pkg::nx_message_t'(ms));
        end
        for (int k = 0; k < 3; k++) begin
            ms = nx_pkg::nx_msg_sig_state_t'(make_msg(nx_pkg::NX_CMD_RESERVED));
            // Would flip bit 7 or claim unwritten map entry 7 if decoded
            ms.target_index = '1;
            ms.state = ms.target_is_seq ? !m_seq[ms.target_index] : !m_comb[ms.target_index];
            send_msg(nx_pkg::nx_message_t'(ms));
        end
        drain();
        compare_all();
        finish_test("sig_updates");
    endtask

    task automatic test_burst();
        logic [31:0] r;
        start_test();
        stall_seen = 1'b0;
        repeat (16) begin // Valid held high throughout
            r = $random(seed);
            send_msg(make_msg(nx_pkg::nx_command_t'(r[1:0])));
        end
        drain();
        compare_all();
        if (!stall_seen) begin
            $display("msg_ready_o never dropped during the back to back burst");
            err_count++;
        end
        finish_test("burst");
    endtask

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before the tests completed");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        seed          = 32'hc19c1437;
        chk_count     = 0;
        err_count     = 0;
        rst_n         = 1'b0;
        msg_valid     = 1'b0;
        msg_data      = '0;
        instr_rd_addr = '0;
        map_rd_idx    = '0;
        m_count       = 0;
        m_map_valid   = '0;
        m_comb        = '0;
        m_seq         = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        start_test(); // Reset state, idle expected at once
        @(negedge clk);
        compare_all();
        finish_test("reset");
        test_instr_loads("instr_loads");
        test_instr_loads("instr_overflow"); // Pushes the total past 16
        check_val("instr_full_o", 32'(instr_full), 32'h1);
        test_map_writes();
        test_sig_updates();
        test_burst();

        $display("total %0d checks, %0d errors", chk_count, err_count);
        if (err_count == 0) $display("ALL CHECKS PASSED");
        else                $display("CHECKS FAILED");
        $finish;
    end

endmodule : tb_nx_node_ctrl

// File: verif/nx_node_ctrl_sva.sv
// ####################################################################
// Stream and update valid assertions, bound into the message decoder
// ####################################################################
`timescale 1ns/1ps

module nx_node_ctrl_sva (
      input logic                clk_i
    , input logic                rst_n_i
    , input nx_pkg::nx_message_t msg_data_i
    , input logic                msg_valid_i
    , input logic                msg_ready_i
    , input logic                map_valid_i
    , input logic                sig_valid_i
    , input logic                instr_valid_i
);

    logic [2:0] upd_valid;
    assign upd_valid = {map_valid_i, sig_valid_i, instr_valid_i};

    // One store per message
    a_one_update: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(upd_valid))
        else $error("more than one update valid in the same cycle");

    // Decode pacing
    a_no_back_to_back: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (|upd_valid) |=> !(|upd_valid))
        else $error("update valid high in two consecutive cycles");

    // Stalled message held by the sender
    a_stream_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (msg_valid_i && !msg_ready_i) |=> (msg_valid_i && $stable(msg_data_i)))
        else $error("stream message dropped or changed while stalled");

endmodule : nx_node_ctrl_sva

bind nx_msg_decoder nx_node_ctrl_sva u_nx_node_ctrl_sva (
      .clk_i         (clk_i)
    , .rst_n_i       (rst_n_i)
    , .msg_data_i    (msg_data_i)
    , .msg_valid_i   (msg_valid_i)
    , .msg_ready_i   (msg_ready_o)
    , .map_valid_i   (map_valid_o)
    , .sig_valid_i   (sig_valid_o)
    , .instr_valid_i (instr_valid_o)
);

// File: logic/nx_node_ctrl.sv
// ####################################################################
// Node control top, decoder feeding instruction, map and state stores
// ####################################################################
`timescale 1ns/1ps

module nx_node_ctrl (
      input  logic                                   clk_i
    , input  logic                                   rst_n_i
    // Inbound stream
    , input  nx_pkg::nx_message_t                    msg_data_i
    , input  logic                                   msg_valid_i
    , output logic                                   msg_ready_o
    , output logic                                   idle_o
    // Instruction read back
    , input  logic [nx_pkg::NX_INSTR_ADDR_WIDTH-1:0] instr_rd_addr_i
    , output logic [nx_pkg::NX_INSTR_WIDTH-1:0]      instr_rd_data_o
    , output logic [nx_pkg::NX_INSTR_CNT_WIDTH-1:0]  instr_count_o
    , output logic                                   instr_full_o
    // Routing table read back
    , input  logic [nx_pkg::NX_OUT_IDX_WIDTH-1:0]    map_rd_idx_i
    , output nx_pkg::nx_map_entry_t                  map_rd_entry_o
    , output logic                                   map_rd_valid_o
    // Input state
    , output logic [nx_pkg::NX_INPUTS-1:0]           comb_state_o
    , output logic [nx_pkg::NX_INPUTS-1:0]           seq_state_o
);

    // Decoder to store links
    logic [nx_pkg::NX_OUT_IDX_WIDTH-1:0] map_idx;
    nx_pkg::nx_map_entry_t               map_entry;
    logic                                map_valid;
    nx_pkg::nx_sig_update_t              sig_upd;
    logic                                sig_valid;
    logic [nx_pkg::NX_INSTR_WIDTH-1:0]   instr_data;
    logic                                instr_valid;

    nx_msg_decoder u_nx_msg_decoder (
          .clk_i         (clk_i)
        , .rst_n_i       (rst_n_i)
        , .msg_data_i    (msg_data_i)
        , .msg_valid_i   (msg_valid_i)
        , .msg_ready_o   (msg_ready_o)
        , .idle_o        (idle_o)
        , .map_idx_o     (map_idx)
        , .map_entry_o   (map_entry)
        , .map_valid_o   (map_valid)
        , .sig_upd_o     (sig_upd)
        , .sig_valid_o   (sig_valid)
        , .instr_data_o  (instr_data)
        , .instr_valid_o (instr_valid)
    );

    nx_instr_store u_nx_instr_store (
          .clk_i         (clk_i)
        , .rst_n_i       (rst_n_i)
        , .instr_data_i  (instr_data)
        , .instr_valid_i (instr_valid)
        , .rd_addr_i     (instr_rd_addr_i)
        , .rd_data_o     (instr_rd_data_o)
        , .count_o       (instr_count_o)
        , .full_o        (instr_full_o)
    );

    nx_map_table u_nx_map_table (
          .clk_i       (clk_i)
        , .rst_n_i     (rst_n_i)
        , .map_idx_i   (map_idx)
        , .map_entry_i (map_entry)
        , .map_valid_i (map_valid)
        , .rd_idx_i    (map_rd_idx_i)
        , .rd_entry_o  (map_rd_entry_o)
        , .rd_valid_o  (map_rd_valid_o)
    );

    nx_input_state u_nx_input_state (
          .clk_i        (clk_i)
        , .rst_n_i      (rst_n_i)
        , .sig_upd_i    (sig_upd)
        , .sig_valid_i  (sig_valid)
        , .comb_state_o (comb_state_o)
        , .seq_state_o  (seq_state_o)
    );

endmodule : nx_node_ctrl

// File: logic/nx_input_state.sv
// ####################################################################
// Combinational and sequential input state vectors
// ####################################################################
`timescale 1ns/1ps

module nx_input_state (
      input  logic                          clk_i
    , input  logic                          rst_n_i
    // Update interface
    , input  nx_pkg::nx_sig_update_t        sig_upd_i
    , input  logic                          sig_valid_i
    // State outputs
    , output logic [nx_pkg::NX_INPUTS-1:0]  comb_state_o
    , output logic [nx_pkg::NX_INPUTS-1:0]  seq_state_o
);

    // is_seq picks the vector, index picks the bit
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            comb_state_o <= '0;
            seq_state_o  <= '0;
        end else if (sig_valid_i) begin
            if (sig_upd_i.is_seq) begin
                seq_state_o[sig_upd_i.index] <= sig_upd_i.state;
            end else begin
                comb_state_o[sig_upd_i.index] <= sig_upd_i.state;
            end
        end
    end

endmodule : nx_input_state

// File: logic/nx_map_table.sv
// ####################################################################
// Output routing table, one entry and valid bit per output
// ####################################################################
`timescale 1ns/1ps

module nx_map_table (
      input  logic                                clk_i
    , input  logic                                rst_n_i
    // Write interface
    , input  logic [nx_pkg::NX_OUT_IDX_WIDTH-1:0] map_idx_i
    , input  nx_pkg::nx_map_entry_t               map_entry_i
    , input  logic                                map_valid_i
    // Read back
    , input  logic [nx_pkg::NX_OUT_IDX_WIDTH-1:0] rd_idx_i
    , output nx_pkg::nx_map_entry_t               rd_entry_o
    , output logic                                rd_valid_o
);

    nx_pkg::nx_map_entry_t          entries_q [nx_pkg::NX_OUTPUTS];
    logic [nx_pkg::NX_OUTPUTS-1:0]  valid_q;  // Entry has been written

    // Valid bits, sticky until reset
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (map_valid_i) begin
            valid_q[map_idx_i] <= 1'b1;
        end
    end

    // Entry contents, last write wins
    always_ff @(posedge clk_i) begin
        if (map_valid_i) begin
            entries_q[map_idx_i] <= map_entry_i;
        end
    end

    // Combinational read port
    assign rd_entry_o = entries_q[rd_idx_i];
    assign rd_valid_o = valid_q[rd_idx_i];

endmodule : nx_map_table

// File: logic/nx_instr_store.sv
// ####################################################################
// Append-only instruction store with load counter and read port
// ####################################################################
`timescale 1ns/1ps

module nx_instr_store (
      input  logic                                   clk_i
    , input  logic                                   rst_n_i
    // Load interface
    , input  logic [nx_pkg::NX_INSTR_WIDTH-1:0]      instr_data_i
    , input  logic                                   instr_valid_i
    // Read back
    , input  logic [nx_pkg::NX_INSTR_ADDR_WIDTH-1:0] rd_addr_i
    , output logic [nx_pkg::NX_INSTR_WIDTH-1:0]      rd_data_o
    // Status
    , output logic [nx_pkg::NX_INSTR_CNT_WIDTH-1:0]  count_o
    , output logic                                   full_o
);

    logic [nx_pkg::NX_INSTR_WIDTH-1:0]     mem_q [nx_pkg::NX_INSTR_DEPTH];
    logic [nx_pkg::NX_INSTR_CNT_WIDTH-1:0] count_q; // Next free slot
    logic                                  do_load;

    assign full_o  = (count_q == nx_pkg::NX_INSTR_CNT_WIDTH'(nx_pkg::NX_INSTR_DEPTH));
    assign count_o = count_q;
    assign do_load = instr_valid_i && !full_o; // Drop once full

    // Load counter, only cleared by reset
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (do_load) begin
            count_q <= count_q + 1'b1;
        end
    end

    // Slot write, address is low bits of count
    always_ff @(posedge clk_i) begin
        if (do_load) begin
            mem_q[count_q[nx_pkg::NX_INSTR_ADDR_WIDTH-1:0]] <= instr_data_i;
        end
    end

    assign rd_data_o = mem_q[rd_addr_i]; // Combinational read

endmodule : nx_instr_store

// File: logic/nx_msg_decoder.sv
// ####################################################################
// Message decoder, buffers inbound messages and issues one registered
// map, signal or instruction update per message
// ####################################################################
`timescale 1ns/1ps

module nx_msg_decoder (
      input  logic                                   clk_i
    , input  logic                                   rst_n_i
    // Inbound stream
    , input  nx_pkg::nx_message_t                    msg_data_i
    , input  logic                                   msg_valid_i
    , output logic                                   msg_ready_o
    // Status
    , output logic                                   idle_o
    // Output mapping update
    , output logic [nx_pkg::NX_OUT_IDX_WIDTH-1:0]    map_idx_o
    , output nx_pkg::nx_map_entry_t                  map_entry_o
    , output logic                                   map_valid_o
    // Signal state update
    , output nx_pkg::nx_sig_update_t                 sig_upd_o
    , output logic                                   sig_valid_o
    // Instruction load
    , output logic [nx_pkg::NX_INSTR_WIDTH-1:0]      instr_data_o
    , output logic                                   instr_valid_o
);

    logic                fifo_empty;
    logic                fifo_full;
    logic                fifo_pop_q;  // Registered pop, paces decode
    nx_pkg::nx_message_t fifo_data;

    // Payload overlays of the FIFO head
    nx_pkg::nx_msg_map_output_t msg_map;
    nx_pkg::nx_msg_sig_state_t  msg_sig;
    nx_pkg::nx_msg_load_instr_t msg_instr;
    nx_pkg::nx_command_t        cmd;

    logic decode; // Head picked up this cycle

    // Four-entry buffer in front of the decoder
    nx_fifo u_nx_fifo (
          .clk_i     (clk_i)
        , .rst_n_i   (rst_n_i)
        , .wr_data_i (msg_data_i)
        , .wr_push_i (msg_valid_i && msg_ready_o)
        , .rd_data_o (fifo_data)
        , .rd_pop_i  (fifo_pop_q)
        , .empty_o   (fifo_empty)
        , .full_o    (fifo_full)
    );

    assign msg_ready_o = !fifo_full; // Back-pressure only when full

    // Nothing buffered, nothing arriving, nothing in flight
    assign idle_o = fifo_empty && !msg_valid_i
                 && !map_valid_o && !sig_valid_o && !instr_valid_o;

    assign msg_map   = nx_pkg::nx_msg_map_output_t'(fifo_data);
    assign msg_sig   = nx_pkg::nx_msg_sig_state_t'(fifo_data);
    assign msg_instr = nx_pkg::nx_msg_load_instr_t'(fifo_data);
    assign cmd       = fifo_data.header.command;

    // Skip the cycle where the previous pop is still in flight
    assign decode = !fifo_empty && !fifo_pop_q;

    // Control: pop and one-cycle valids
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fifo_pop_q    <= 1'b0;
            map_valid_o   <= 1'b0;
            sig_valid_o   <= 1'b0;
            instr_valid_o <= 1'b0;
        end else begin
            fifo_pop_q    <= decode; // Reserved commands popped too
            map_valid_o   <= decode && (cmd == nx_pkg::NX_CMD_MAP_OUTPUT);
            sig_valid_o   <= decode && (cmd == nx_pkg::NX_CMD_SIG_STATE);
            instr_valid_o <= decode && (cmd == nx_pkg::NX_CMD_LOAD_INSTR);
        end
    end

    // Payload fields, captured with every decode
    always_ff @(posedge clk_i) begin
        if (decode) begin
            map_idx_o                 <= msg_map.source_index;
            map_entry_o.target_row    <= msg_map.target_row;
            map_entry_o.target_column <= msg_map.target_column;
            map_entry_o.target_index  <= msg_map.target_index;
            map_entry_o.target_is_seq <= msg_map.target_is_seq;
            sig_upd_o.index           <= msg_sig.target_index;
            sig_upd_o.is_seq          <= msg_sig.target_is_seq;
            sig_upd_o.state           <= msg_sig.state;
            instr_data_o              <= msg_instr.instruction;
        end
    end

endmodule : nx_msg_decoder

// File: logic/nx_fifo.sv
// ####################################################################
// Inbound message FIFO, circular buffer with occupancy count
// ####################################################################
`timescale 1ns/1ps

module nx_fifo (
      input  logic                clk_i
    , input  logic                rst_n_i
    // Write side
    , input  nx_pkg::nx_message_t wr_data_i
    , input  logic                wr_push_i
    // Read side
    , output nx_pkg::nx_message_t rd_data_o
    , input  logic                rd_pop_i
    // Status
    , output logic                empty_o
    , output logic                full_o
);

    // Storage, no reset needed
    nx_pkg::nx_message_t mem_q [nx_pkg::NX_FIFO_DEPTH];

    logic [nx_pkg::NX_FIFO_PTR_WIDTH-1:0] wr_ptr_q;
    logic [nx_pkg::NX_FIFO_PTR_WIDTH-1:0] rd_ptr_q;
    logic [nx_pkg::NX_FIFO_CNT_WIDTH-1:0] count_q;

    logic do_push;
    logic do_pop;

    // Qualify requests against status
    assign do_push = wr_push_i && !full_o;  // Push while full dropped
    assign do_pop  = rd_pop_i && !empty_o;  // Pop while empty ignored

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == nx_pkg::NX_FIFO_CNT_WIDTH'(nx_pkg::NX_FIFO_DEPTH));

    // Head entry, combinational
    assign rd_data_o = mem_q[rd_ptr_q];

    // Pointers and count
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1; // Wraps at depth (power of two)
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q; // Both or neither
            endcase
        end
    end

    // Data write
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= wr_data_i;
        end
    end

endmodule : nx_fifo

// File: logic/nx_pkg.sv
// ####################################################################
// Node control package: message format, commands and payload types
// ####################################################################
package nx_pkg;

    // Sizing
    localparam int NX_MSG_WIDTH      = 32;
    localparam int NX_ADDR_ROW_WIDTH = 4;
    localparam int NX_ADDR_COL_WIDTH = 4;
    localparam int NX_INSTR_WIDTH    = 15;
    localparam int NX_INPUTS         = 8;
    localparam int NX_OUTPUTS        = 8;
    localparam int NX_INSTR_DEPTH    = 16;
    localparam int NX_FIFO_DEPTH     = 4;

    // Derived widths
    localparam int NX_IN_IDX_WIDTH     = $clog2(NX_INPUTS);      // Input select
    localparam int NX_OUT_IDX_WIDTH    = $clog2(NX_OUTPUTS);     // Output select
    localparam int NX_INSTR_ADDR_WIDTH = $clog2(NX_INSTR_DEPTH);
    localparam int NX_INSTR_CNT_WIDTH  = $clog2(NX_INSTR_DEPTH + 1); // Counts 0..depth
    localparam int NX_FIFO_PTR_WIDTH   = $clog2(NX_FIFO_DEPTH);
    localparam int NX_FIFO_CNT_WIDTH   = $clog2(NX_FIFO_DEPTH + 1);

    // Message commands, 2-bit field in the header
    typedef enum logic [1:0] {
        NX_CMD_LOAD_INSTR = 2'd0,
        NX_CMD_MAP_OUTPUT = 2'd1,
        NX_CMD_SIG_STATE  = 2'd2,
        NX_CMD_RESERVED   = 2'd3 // Dropped by the decoder
    } nx_command_t;

    typedef struct packed {
        logic [NX_ADDR_ROW_WIDTH-1:0] row;
        logic [NX_ADDR_COL_WIDTH-1:0] column;
        nx_command_t                  command;
    } nx_msg_header_t;

    localparam int NX_PAYLOAD_WIDTH = NX_MSG_WIDTH - $bits(nx_msg_header_t);

    // Generic view, header sits in the MSBs
    typedef struct packed {
        nx_msg_header_t              header;
        logic [NX_PAYLOAD_WIDTH-1:0] payload;
    } nx_message_t;

    // Output mapping overlay
    typedef struct packed {
        nx_msg_header_t               header;
        logic [NX_OUT_IDX_WIDTH-1:0]  source_index;  // Local output
        logic [NX_ADDR_ROW_WIDTH-1:0] target_row;
        logic [NX_ADDR_COL_WIDTH-1:0] target_column;
        logic [NX_IN_IDX_WIDTH-1:0]   target_index;  // Remote input
        logic                         target_is_seq;
        logic [NX_PAYLOAD_WIDTH-NX_OUT_IDX_WIDTH-NX_ADDR_ROW_WIDTH
               -NX_ADDR_COL_WIDTH-NX_IN_IDX_WIDTH-2:0] padding;
    } nx_msg_map_output_t;

    // Signal state overlay
    typedef struct packed {
        nx_msg_header_t                              header;
        logic [NX_IN_IDX_WIDTH-1:0]                  target_index;
        logic                                        target_is_seq;
        logic                                        state;
        logic [NX_PAYLOAD_WIDTH-NX_IN_IDX_WIDTH-3:0] padding;
    } nx_msg_sig_state_t;

    // Instruction load overlay
    typedef struct packed {
        nx_msg_header_t                             header;
        logic [NX_INSTR_WIDTH-1:0]                  instruction;
        logic [NX_PAYLOAD_WIDTH-NX_INSTR_WIDTH-1:0] padding;
    } nx_msg_load_instr_t;

    // One routing table entry
    typedef struct packed {
        logic [NX_ADDR_ROW_WIDTH-1:0] target_row;
        logic [NX_ADDR_COL_WIDTH-1:0] target_column;
        logic [NX_IN_IDX_WIDTH-1:0]   target_index;
        logic                         target_is_seq;
    } nx_map_entry_t;

    // Input state write
    typedef struct packed {
        logic [NX_IN_IDX_WIDTH-1:0] index;
        logic                       is_seq; // Selects seq vs comb vector
        logic                       state;
    } nx_sig_update_t;

endpackage : nx_pkg
